// File: logic/pcie_tlp_pkg.sv
// PCIe TLP field types and the max read request size encoding for the read requester
`default_nettype none

package pcie_tlp_pkg;

    typedef logic [31:0] addr_t;      // Byte address carried in a memory read request
    typedef logic [15:0] byte_len_t;  // Descriptor length, always a nonzero multiple of 4
    typedef logic [10:0] dw_len_t;    // TLP length field in dwords
    typedef logic [3:0]  tag_t;       // Non-posted request tag

    // Max read request size field of the device control register
    typedef enum logic [2:0] {
        MRR_128  = 3'd0,
        MRR_256  = 3'd1,
        MRR_512  = 3'd2,
        MRR_1024 = 3'd3
    } mrr_e;

    // Payload bytes covered by a single CplD credit
    localparam int unsigned CPLD_UNIT_BYTES = 16;

    // Largest read request in bytes for a given max read request code
    function automatic byte_len_t mrr_bytes(input mrr_e code);
        byte_len_t base;
        base = 16'd128;
        return base << code;  // 128 bytes doubled once per code step
    endfunction

endpackage

`default_nettype wire

// File: logic/dma_read_pkg.sv
// Read engine limits, credit counter types and splitter states
`default_nettype none

package dma_read_pkg;

    localparam int unsigned TAG_COUNT  = 16;  // Tags available for outstanding reads
    localparam int unsigned CPLH_LIMIT = 8;   // Completion headers allowed in flight
    localparam int unsigned CPLD_LIMIT = 96;  // Completion data credits allowed in flight

    typedef logic [3:0] hdr_cnt_t;   // Header credits in use, up to CPLH_LIMIT
    typedef logic [7:0] data_cnt_t;  // Data credits in use or the cost of one request

    // Descriptor splitter states
    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,  // Waiting for a descriptor
        S_ISSUE = 2'd1,  // Cutting and issuing read requests
        S_DRAIN = 2'd2   // All requests out, waiting for completions
    } split_state_e;

endpackage

`default_nettype wire

// File: logic/read_req_fsm.sv
// Descriptor splitter FSM that cuts one read into max read request sized requests
`default_nettype none
`timescale 1ns/1ps

module read_req_fsm (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire pcie_tlp_pkg::mrr_e       cfg_max_read_req,
    input  wire                           desc_valid,
    output logic                          desc_ready,
    input  wire pcie_tlp_pkg::addr_t      desc_addr,
    input  wire pcie_tlp_pkg::byte_len_t  desc_len,
    input  wire                           issue_ok,
    input  wire pcie_tlp_pkg::tag_t       free_tag,
    input  wire                           pool_empty,
    output logic                          rq_valid,
    output pcie_tlp_pkg::addr_t           rq_addr,
    output pcie_tlp_pkg::dw_len_t         rq_len_dw,
    output pcie_tlp_pkg::tag_t            rq_tag,
    output dma_read_pkg::data_cnt_t       req_cost,
    output logic                          done
);

    import pcie_tlp_pkg::*;
    import dma_read_pkg::*;

    split_state_e state;
    split_state_e state_nxt;
    addr_t        cur_addr;   // Address of the next request to go out
    byte_len_t    rem_len;    // Bytes of the descriptor not yet requested
    byte_len_t    chunk_len;  // Largest request allowed by the link setting
    byte_len_t    req_bytes;  // Size of the request currently presented
    logic         accept;
    logic         last_req;

    assign chunk_len = mrr_bytes(cfg_max_read_req);
    assign req_bytes = (rem_len < chunk_len) ? rem_len : chunk_len;
    assign last_req  = (rem_len <= chunk_len);  // Remainder fits in this request

    // Cost in CplD credits, rounded up to whole 16 byte units
    assign req_cost = data_cnt_t'((req_bytes + byte_len_t'(CPLD_UNIT_BYTES - 1))
                                  / CPLD_UNIT_BYTES);

    assign rq_valid  = (state == S_ISSUE) && issue_ok;  // Credits are the only back-pressure
    assign rq_addr   = cur_addr;
    assign rq_len_dw = dw_len_t'(req_bytes >> 2);
    assign rq_tag    = free_tag;

    // Done fires while draining once the last tag has come back
    assign done       = (state == S_DRAIN) && pool_empty;
    assign desc_ready = (state == S_IDLE) || done;
    assign accept     = desc_valid && desc_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (accept) begin
                    state_nxt = S_ISSUE;
                end
            end
            S_ISSUE: begin
                if (rq_valid && last_req) begin
                    state_nxt = S_DRAIN;
                end
            end
            S_DRAIN: begin
                if (accept) begin
                    state_nxt = S_ISSUE;  // Next descriptor taken in the done cycle
                end else if (pool_empty) begin
                    state_nxt = S_IDLE;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Request window walks forward by the size of each issued request
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_addr <= desc_addr;
            rem_len  <= desc_len;
        end else if (rq_valid) begin
            cur_addr <= cur_addr + addr_t'(req_bytes);
            rem_len  <= rem_len - req_bytes;
        end
    end

endmodule

`default_nettype wire

// File: logic/cpl_credit_counter.sv
// Completion header and data credit tracker that grants permission to issue reads
`default_nettype none
`timescale 1ns/1ps

module cpl_credit_counter (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire                           issue,
    input  wire dma_read_pkg::data_cnt_t  req_cost,
    input  wire                           tag_avail,
    input  wire                           rel_valid,
    input  wire dma_read_pkg::data_cnt_t  rel_cost,
    output logic                          issue_ok,
    output dma_read_pkg::hdr_cnt_t        hdr_used,
    output dma_read_pkg::data_cnt_t       data_used
);

    import dma_read_pkg::*;

    logic [4:0] hdr_sum;   // Header credits in use if one more request goes out
    logic [8:0] data_sum;  // Data credits in use if the presented request goes out
    data_cnt_t  data_inc;
    data_cnt_t  data_dec;

    assign hdr_sum  = {1'b0, hdr_used} + 5'd1;
    assign data_sum = {1'b0, data_used} + {1'b0, req_cost};

    // A release in this cycle is not counted until the next one
    assign issue_ok = (hdr_sum <= CPLH_LIMIT) && (data_sum <= CPLD_LIMIT) && tag_avail;

    assign data_inc = issue ? req_cost : '0;
    assign data_dec = rel_valid ? rel_cost : '0;

    // Issue and release may land in the same cycle and both take effect
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hdr_used  <= '0;
            data_used <= '0;
        end else begin
            hdr_used  <= hdr_used + hdr_cnt_t'(issue) - hdr_cnt_t'(rel_valid);
            data_used <= data_used + data_inc - data_dec;
        end
    end

endmodule

`default_nettype wire

// File: logic/tag_pool.sv
// Tag allocator with a busy bitmap and the data credit cost stored per outstanding tag
`default_nettype none
`timescale 1ns/1ps

module tag_pool (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire                           alloc,
    input  wire dma_read_pkg::data_cnt_t  alloc_cost,
    input  wire                           cpl_valid,
    input  wire pcie_tlp_pkg::tag_t       cpl_tag,
    output pcie_tlp_pkg::tag_t            free_tag,
    output logic                          tag_avail,
    output logic                          pool_empty,
    output logic                          rel_valid,
    output dma_read_pkg::data_cnt_t       rel_cost
);

    import pcie_tlp_pkg::*;
    import dma_read_pkg::*;

    logic [TAG_COUNT-1:0] busy;                  // One bit per tag with a read outstanding
    data_cnt_t            cost_mem [TAG_COUNT];  // Credit cost charged when each tag went out

    // Lowest numbered free tag wins, so scan from the top down
    always_comb begin
        free_tag = '0;
        for (int i = TAG_COUNT - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_tag = tag_t'(i);
            end
        end
    end

    assign tag_avail  = ~&busy;
    assign pool_empty = ~|busy;

    // Completions for tags that are not out are dropped here
    assign rel_valid = cpl_valid && busy[cpl_tag];
    assign rel_cost  = cost_mem[cpl_tag];

    // Alloc always picks a free tag and release a busy one, so they never collide
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
        end else begin
            if (rel_valid) begin
                busy[cpl_tag] <= 1'b0;
            end
            if (alloc) begin
                busy[free_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            cost_mem[free_tag] <= alloc_cost;
        end
    end

endmodule

`default_nettype wire

// File: logic/dma_read_top.sv
// PCIe read requester top level joining the splitter, credit counter and tag pool
`default_nettype none
`timescale 1ns/1ps

module dma_read_top (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire pcie_tlp_pkg::mrr_e       cfg_max_read_req,
    input  wire                           desc_valid,
    output logic                          desc_ready,
    input  wire pcie_tlp_pkg::addr_t      desc_addr,
    input  wire pcie_tlp_pkg::byte_len_t  desc_len,
    output logic                          rq_valid,
    output pcie_tlp_pkg::addr_t           rq_addr,
    output pcie_tlp_pkg::dw_len_t         rq_len_dw,
    output pcie_tlp_pkg::tag_t            rq_tag,
    input  wire                           cpl_valid,
    input  wire pcie_tlp_pkg::tag_t       cpl_tag,
    output logic                          done
);

    import pcie_tlp_pkg::*;
    import dma_read_pkg::*;

    logic      issue_ok;
    logic      tag_avail;
    logic      pool_empty;
    logic      rel_valid;
    data_cnt_t req_cost;  // Credit cost of the request the splitter is presenting
    data_cnt_t rel_cost;  // Credit cost returned by a completing tag
    tag_t      free_tag;

    read_req_fsm read_req_fsm_inst (
        .clk(clk),
        .arst_n(arst_n),
        .cfg_max_read_req(cfg_max_read_req),
        .desc_valid(desc_valid),
        .desc_ready(desc_ready),
        .desc_addr(desc_addr),
        .desc_len(desc_len),
        .issue_ok(issue_ok),
        .free_tag(free_tag),
        .pool_empty(pool_empty),
        .rq_valid(rq_valid),
        .rq_addr(rq_addr),
        .rq_len_dw(rq_len_dw),
        .rq_tag(rq_tag),
        .req_cost(req_cost),
        .done(done)
    );

    // Occupancy outputs are watched by the bound checker on this instance
    cpl_credit_counter cpl_credit_counter_inst (
        .clk(clk),
        .arst_n(arst_n),
        .issue(rq_valid),
        .req_cost(req_cost),
        .tag_avail(tag_avail),
        .rel_valid(rel_valid),
        .rel_cost(rel_cost),
        .issue_ok(issue_ok),
        .hdr_used(),
        .data_used()
    );

    tag_pool tag_pool_inst (
        .clk(clk),
        .arst_n(arst_n),
        .alloc(rq_valid),
        .alloc_cost(req_cost),
        .cpl_valid(cpl_valid),
        .cpl_tag(cpl_tag),
        .free_tag(free_tag),
        .tag_avail(tag_avail),
        .pool_empty(pool_empty),
        .rel_valid(rel_valid),
        .rel_cost(rel_cost)
    );

endmodule

`default_nettype wire

// File: tb/dma_read_assert.sv
// Concurrent checks on completion credit occupancy, bound into the credit counter
`default_nettype none
`timescale 1ns/1ps

module dma_read_assert (
    input wire                           clk,
    input wire                           arst_n,
    input wire dma_read_pkg::hdr_cnt_t   hdr_used,
    input wire dma_read_pkg::data_cnt_t  data_used,
    input wire                           rel_valid
);

    import dma_read_pkg::*;

    int unsigned fail_cnt = 0;

    hdr_limit_a: assert property (@(posedge clk) disable iff (!arst_n)
        hdr_used <= CPLH_LIMIT)
        else begin
            $error("Completion header credits in use exceed the limit");
            fail_cnt++;
        end

    data_limit_a: assert property (@(posedge clk) disable iff (!arst_n)
        data_used <= CPLD_LIMIT)
        else begin
            $error("Completion data credits in use exceed the limit");
            fail_cnt++;
        end

    // A release needs at least one header credit to return
    rel_nonzero_a: assert property (@(posedge clk) disable iff (!arst_n)
        rel_valid |-> (hdr_used != '0))
        else begin
            $error("Credit release with no header credits in use");
            fail_cnt++;
        end

endmodule

bind cpl_credit_counter dma_read_assert dma_read_assert_inst (
    .clk(clk),
    .arst_n(arst_n),
    .hdr_used(hdr_used),
    .data_used(data_used),
    .rel_valid(rel_valid)
);

`default_nettype wire

// File: tb/tb_dma_read_top.sv
// Testbench for the PCIe read requester with a host agent, completer model and reference splitter
`default_nettype none
`timescale 1ns/1ps

module tb_dma_read_top;

    import pcie_tlp_pkg::*;
    import dma_read_pkg::*;

    logic      clk;
    logic      arst_n;
    mrr_e      cfg_max_read_req;
    logic      desc_valid;
    logic      desc_ready;
    addr_t     desc_addr;
    byte_len_t desc_len;
    logic      rq_valid;
    addr_t     rq_addr;
    dw_len_t   rq_len_dw;
    tag_t      rq_tag;
    logic      cpl_valid;
    tag_t      cpl_tag;
    logic      done;

    addr_t                exp_addr_q[$];  // Expected requests in issue order
    dw_len_t              exp_len_q[$];
    tag_t                 pending_q[$];   // Issued tags the completer has not returned yet
    logic [TAG_COUNT-1:0] outstanding;
    data_cnt_t            tag_cost [TAG_COUNT];
    int                   hdr_inflight;
    int                   data_inflight;
    int                   issued_cnt;
    int                   done_cnt;
    int                   len_sum_dw;
    int                   fit_n;          // Requests that fit from an empty credit pool
    logic                 desc_active;
    logic                 hold;           // Completer withholds returns while high
    logic                 force_release;  // Returns the oldest tag even while held
    logic                 stray_req;
    tag_t                 stray_tag;
    string                test_name;

    dma_read_top DUT (.*);

    always #4 clk = ~clk;

    // Requests are cut by size only, with no alignment to chunk boundaries
    function automatic void split_ref(input addr_t addr, input byte_len_t len, input mrr_e code);
        int unsigned chunk;
        int unsigned rem;
        int unsigned step;
        chunk = 128 << int'(code);
        rem   = len;
        while (rem > 0) begin
            step = (rem < chunk) ? rem : chunk;
            exp_addr_q.push_back(addr);
            exp_len_q.push_back(dw_len_t'(step / 4));
            addr = addr + step;
            rem  = rem - step;
        end
    endfunction

    function automatic int cost_of(input dw_len_t len_dw);
        return (int'(len_dw) * 4 + 15) / 16;  // Whole 16 byte units, rounded up
    endfunction

    function automatic int fit_count();
        int hdr;
        int data;
        int n;
        hdr  = 0;
        data = 0;
        n    = 0;
        while (n < exp_len_q.size() && n < TAG_COUNT && hdr + 1 <= CPLH_LIMIT
               && data + cost_of(exp_len_q[n]) <= CPLD_LIMIT) begin
            hdr  = hdr + 1;
            data = data + cost_of(exp_len_q[n]);
            n    = n + 1;
        end
        return n;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_len(input string name, input dw_len_t exp, input dw_len_t act);
        if (exp !== act) begin
            abort_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
        end
    endtask

    // Issue is checked before a same cycle release frees a tag
    always @(posedge clk) begin
        if (arst_n) begin
            if (rq_valid) begin
                if (!desc_active || exp_addr_q.size() == 0) begin
                    abort_run("A read request was issued with no descriptor pending");
                end
                if (outstanding[rq_tag]) begin
                    abort_run($sformatf("Tag %0d was issued while still outstanding", rq_tag));
                end
                check_addr({test_name, " rq_addr"}, exp_addr_q.pop_front(), rq_addr);
                check_len({test_name, " rq_len_dw"}, exp_len_q.pop_front(), rq_len_dw);
                if (hdr_inflight + 1 > CPLH_LIMIT
                    || data_inflight + cost_of(rq_len_dw) > CPLD_LIMIT) begin
                    abort_run("A read request was issued beyond the completion credit limits");
                end
                outstanding[rq_tag] = 1'b1;
                tag_cost[rq_tag]    = data_cnt_t'(cost_of(rq_len_dw));
                hdr_inflight        = hdr_inflight + 1;
                data_inflight       = data_inflight + cost_of(rq_len_dw);
                len_sum_dw          = len_sum_dw + int'(rq_len_dw);
                issued_cnt          = issued_cnt + 1;
                pending_q.push_back(rq_tag);
            end
            if (cpl_valid && outstanding[cpl_tag]) begin
                outstanding[cpl_tag] = 1'b0;
                hdr_inflight         = hdr_inflight - 1;
                data_inflight        = data_inflight - int'(tag_cost[cpl_tag]);
            end
            if (done) begin
                if (!desc_active || outstanding != '0 || exp_addr_q.size() != 0) begin
                    abort_run("done pulsed with no descriptor or with work still open");
                end
                check_len({test_name, " length sum"}, dw_len_t'(desc_len >> 2),
                          dw_len_t'(len_sum_dw));
                check_flag({test_name, " desc_ready at done"}, 1'b1, desc_ready);
                desc_active = 1'b0;
                done_cnt    = done_cnt + 1;
            end
        end
    end

    // Completer model returns tags in random order after random delays
    always @(negedge clk) begin
        int idx;
        cpl_valid = 1'b0;
        if (stray_req) begin
            cpl_tag   = stray_tag;
            cpl_valid = 1'b1;
            stray_req = 1'b0;
        end else if (pending_q.size() > 0
                     && (force_release || (!hold && $urandom % 3 == 0))) begin
            idx = force_release ? 0 : int'($urandom % pending_q.size());
            cpl_tag = pending_q[idx];
            pending_q.delete(idx);
            cpl_valid     = 1'b1;
            force_release = 1'b0;
        end
    end

    task automatic wait_issued(input int n);
        int cycles;
        cycles = 0;
        while (issued_cnt < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2000) begin
                abort_run("Timed out waiting for read requests to issue");
            end
        end
    endtask

    task automatic wait_done(input int n);
        int cycles;
        cycles = 0;
        while (done_cnt < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20000) begin
                abort_run("Timed out waiting for done");
            end
        end
    endtask

    task automatic send_desc(input addr_t addr, input byte_len_t len, input mrr_e code);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!desc_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > 1000) begin
                abort_run("Timed out waiting for desc_ready");
            end
        end
        cfg_max_read_req = code;
        split_ref(addr, len, code);
        fit_n       = fit_count();
        len_sum_dw  = 0;
        desc_active = 1'b1;
        desc_addr   = addr;
        desc_len    = len;
        desc_valid  = 1'b1;  // Accepted at the next rising edge since desc_ready is high
        @(negedge clk);
        desc_valid = 1'b0;
    endtask

    task automatic stall_test(input mrr_e code);
        int   base;
        int   n_fit;
        logic next_fits;
        test_name = $sformatf("stall_mrr%0d", int'(code));
        base      = issued_cnt;
        hold      = 1'b1;
        send_desc(32'h0001_0000, 16'd4096, code);
        n_fit = fit_n;
        wait_issued(base + n_fit);
        repeat (30) @(negedge clk);  // Window in which no further request may issue
        if (issued_cnt != base + n_fit) begin
            abort_run($sformatf("Stall after %0d requests where the credit model allows %0d",
                                issued_cnt - base, n_fit));
        end
        // The header freed by the release is reused by the next one
        next_fits = (exp_len_q.size() > 0) && (data_inflight - int'(tag_cost[pending_q[0]])
                     + cost_of(exp_len_q[0]) <= CPLD_LIMIT);
        @(posedge clk);
        force_release = 1'b1;
        if (next_fits) begin
            wait_issued(base + n_fit + 1);
        end
        hold = 1'b0;
        wait_done(done_cnt + 1);
    endtask

    initial begin
        int   base;
        addr_t     addr;
        byte_len_t len;
        void'($urandom(32'h87e3_aa2f));
        clk              = 1'b0;
        arst_n           = 1'b0;
        cfg_max_read_req = MRR_128;
        desc_valid       = 1'b0;
        desc_addr        = '0;
        desc_len         = '0;
        cpl_valid        = 1'b0;
        cpl_tag          = '0;
        outstanding      = '0;
        hdr_inflight     = 0;
        data_inflight    = 0;
        issued_cnt       = 0;
        done_cnt         = 0;
        len_sum_dw       = 0;
        fit_n            = 0;
        desc_active      = 1'b0;
        hold             = 1'b0;
        force_release    = 1'b0;
        stray_req        = 1'b0;
        stray_tag        = '0;
        test_name        = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_flag("reset desc_ready", 1'b1, desc_ready);
        check_flag("reset rq_valid", 1'b0, rq_valid);
        check_flag("reset done", 1'b0, done);

        for (int c = 0; c < 4; c++) begin
            test_name = $sformatf("split_mrr%0d", c);
            send_desc(32'h0000_2000, byte_len_t'(128 << c), mrr_e'(c));  // Exactly one chunk
            wait_done(done_cnt + 1);
            for (int i = 0; i < 6; i++) begin
                addr = $urandom & 32'hffff_fffc;
                len  = byte_len_t'((($urandom % 1024) + 1) * 4);
                send_desc(addr, len, mrr_e'(c));
                wait_done(done_cnt + 1);
            end
        end

        for (int c = 0; c < 4; c++) begin
            stall_test(mrr_e'(c));
        end

        test_name = "stray";
        base      = issued_cnt;
        @(posedge clk);
        stray_tag = 4'd5;
        stray_req = 1'b1;
        repeat (10) @(negedge clk);
        if (issued_cnt != base || desc_active) begin
            abort_run("A completion on an idle tag caused a request or done");
        end

        if (DUT.cpl_credit_counter_inst.dma_read_assert_inst.fail_cnt != 0) begin
            abort_run("A bound credit assertion failed during the run");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
logic/pcie_tlp_pkg.sv
logic/dma_read_pkg.sv
logic/read_req_fsm.sv
logic/cpl_credit_counter.sv
logic/tag_pool.sv
logic/dma_read_top.sv
tb/dma_read_assert.sv
tb/tb_dma_read_top.sv

// File: Bender.yml
package:
  name: dma_read

sources:
  - logic/pcie_tlp_pkg.sv
  - logic/dma_read_pkg.sv
  - logic/read_req_fsm.sv
  - logic/cpl_credit_counter.sv
  - logic/tag_pool.sv
  - logic/dma_read_top.sv
  - target: test
    files:
      - tb/dma_read_assert.sv
      - tb/tb_dma_read_top.sv
